// File: files.f
+incdir+test
src/rvc_isa_pkg.sv
src/rvc_types_pkg.sv
src/rvc_mem_expander.sv
src/rvc_alu_ctrl_expander.sv
src/rvc_expand_merge.sv
src/rvc_decoder.sv
test/tb_rvc_decoder.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the RVC decoder testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -f files.f --top-module tb_rvc_decoder \
    -o tb_rvc_decoder > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/tb_rvc_decoder > sim.log 2>&1
cat sim.log
grep -qx "SIMULATION PASSED" sim.log && echo "Result: pass" || { echo "Result: fail"; exit 1; }

// File: test/rvc_ref_model.svh
`ifndef RVC_REF_MODEL_SVH
`define RVC_REF_MODEL_SVH

function automatic logic [31:0] itype_word(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] stype_word(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
endfunction

function automatic logic [31:0] btype_word(input logic [12:0] off, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
endfunction

function automatic logic [31:0] jtype_word(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
endfunction

function automatic logic [31:0] rtype_word(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
endfunction

// Expected decode of one fetch word, per the RV32C tables
function automatic rvc_types_pkg::rvc_decode_t ref_decode(input logic [31:0] word);
    rvc_types_pkg::rvc_decode_t res;
    logic [15:0] c;
    logic [4:0]  rd;
    logic [4:0]  rs2;
    logic [4:0]  rdp;
    logic [4:0]  rs2p;
    logic [11:0] imm6;
    logic [11:0] uimm;
    logic [20:0] joff;
    logic [12:0] boff;
    logic [31:0] expanded;
    logic        bad;
    c        = word[15:0];
    rd       = c[11:7];
    rs2      = c[6:2];
    rdp      = {2'b01, c[9:7]};
    rs2p     = {2'b01, c[4:2]};
    imm6     = {{6{c[12]}}, c[12], c[6:2]};
    joff     = {{10{c[12]}}, c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3], 1'b0};
    boff     = {{5{c[12]}}, c[6:5], c[2], c[11:10], c[4:3], 1'b0};
    expanded = word;
    bad      = 1'b0;
    case (c[1:0])
        2'b00: begin
            uimm = {5'b0, c[5], c[12:10], c[6], 2'b00}; // LW/SW offset
            case (c[15:13])
                3'b000: begin
                    uimm     = {2'b00, c[10:7], c[12:11], c[5], c[6], 2'b00};
                    bad      = (uimm == 12'd0);
                    expanded = itype_word(uimm, 5'd2, 3'b000, rs2p, 7'b0010011);
                end
                3'b010:  expanded = itype_word(uimm, rdp, 3'b010, rs2p, 7'b0000011);
                3'b110:  expanded = stype_word(uimm, rs2p, rdp, 3'b010);
                default: bad = 1'b1;
            endcase
        end
        2'b01: begin
            case (c[15:13])
                3'b000: expanded = itype_word(imm6, rd, 3'b000, rd, 7'b0010011);
                3'b001: expanded = jtype_word(joff, 5'd1);
                3'b010: expanded = itype_word(imm6, 5'd0, 3'b000, rd, 7'b0010011);
                3'b011: begin
                    if (rd == 5'd2) begin
                        uimm     = {{3{c[12]}}, c[4:3], c[5], c[2], c[6], 4'b0000};
                        expanded = itype_word(uimm, 5'd2, 3'b000, 5'd2, 7'b0010011);
                    end else begin
                        expanded = {{15{c[12]}}, c[6:2], rd, 7'b0110111};
                    end
                    bad = (c[12] == 1'b0) && (c[6:2] == 5'd0);
                end
                3'b100: begin
                    case (c[11:10])
                        2'b00: begin
                            expanded = itype_word({7'b0000000, c[6:2]}, rdp, 3'b101, rdp,
                                                  7'b0010011);
                            bad      = c[12];
                        end
                        2'b01: begin
                            expanded = itype_word({7'b0100000, c[6:2]}, rdp, 3'b101, rdp,
                                                  7'b0010011);
                            bad      = c[12];
                        end
                        2'b10: expanded = itype_word(imm6, rdp, 3'b111, rdp, 7'b0010011);
                        default: begin
                            bad = c[12];
                            case (c[6:5])
                                2'b00:   expanded = rtype_word(7'b0100000, rs2p, rdp, 3'b000, rdp);
                                2'b01:   expanded = rtype_word(7'b0000000, rs2p, rdp, 3'b100, rdp);
                                2'b10:   expanded = rtype_word(7'b0000000, rs2p, rdp, 3'b110, rdp);
                                default: expanded = rtype_word(7'b0000000, rs2p, rdp, 3'b111, rdp);
                            endcase
                        end
                    endcase
                end
                3'b101:  expanded = jtype_word(joff, 5'd0);
                3'b110:  expanded = btype_word(boff, 5'd0, rdp, 3'b000);
                default: expanded = btype_word(boff, 5'd0, rdp, 3'b001);
            endcase
        end
        2'b10: begin
            case (c[15:13])
                3'b000: begin
                    expanded = itype_word({7'b0, c[6:2]}, rd, 3'b001, rd, 7'b0010011);
                    bad      = c[12];
                end
                3'b010: begin
                    uimm     = {4'b0, c[3:2], c[12], c[6:4], 2'b00};
                    expanded = itype_word(uimm, 5'd2, 3'b010, rd, 7'b0000011);
                    bad      = (rd == 5'd0);
                end
                3'b100: begin
                    if (!c[12]) begin
                        if (rs2 == 5'd0) begin // JR
                            expanded = itype_word(12'd0, rd, 3'b000, 5'd0, 7'b1100111);
                            bad      = (rd == 5'd0);
                        end else begin
                            expanded = rtype_word(7'd0, rs2, 5'd0, 3'b000, rd);
                        end
                    end else if (rs2 != 5'd0) begin
                        expanded = rtype_word(7'd0, rs2, rd, 3'b000, rd);
                    end else if (rd == 5'd0) begin
                        expanded = 32'h0010_0073;
                    end else begin
                        expanded = itype_word(12'd0, rd, 3'b000, 5'd1, 7'b1100111);
                    end
                end
                3'b110: begin
                    uimm     = {4'b0, c[8:7], c[12:9], 2'b00};
                    expanded = stype_word(uimm, rs2, 5'd2, 3'b010);
                end
                default: bad = 1'b1;
            endcase
        end
        default: ; // Full-width word
    endcase
    res.is_compressed = (c[1:0] != 2'b11);
    res.illegal       = bad;
    res.instr         = bad ? word : expanded;
    return res;
endfunction

`endif

// File: test/tb_rvc_decoder.sv
`timescale 1ns/1ps

module tb_rvc_decoder;

    logic                       i_clk = 1'b0;
    logic                       i_arst_n;
    logic                       i_valid;
    logic [31:0]                i_instr;
    logic                       o_valid;
    rvc_types_pkg::rvc_decode_t o_decode;

    rvc_types_pkg::rvc_decode_t exp_q[$];
    string                      name_q[$];
    integer                     seed       = 40077;
    int                         chk_errs   = 0;
    int                         proto_errs = 0;
    int                         tmo_errs   = 0;
    logic                       exp_valid  = 1'b0;

    `include "rvc_ref_model.svh"

    rvc_decoder u_rvc_decoder (
        .i_clk    (i_clk),
        .i_arst_n (i_arst_n),
        .i_valid  (i_valid),
        .i_instr  (i_instr),
        .o_valid  (o_valid),
        .o_decode (o_decode)
    );

    initial begin
        forever #20 i_clk = ~i_clk;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            chk_errs++;
            $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic send_word(input logic [31:0] word, input string name);
        @(posedge i_clk);
        #2;
        i_valid = 1'b1;
        i_instr = word;
        exp_q.push_back(ref_decode(word));
        name_q.push_back(name);
    endtask

    task automatic send_half(input logic [15:0] half, input string name);
        logic [31:0] r;
        r = $random(seed);
        send_word({r[31:16], half}, name); // Random upper halfword
    endtask

    task automatic idle_cycles(input int n);
        logic [31:0] r;
        for (int k = 0; k < n; k++) begin
            @(posedge i_clk);
            #2;
            r       = $random(seed);
            i_valid = 1'b0;
            i_instr = r;
        end
    endtask

    // Checks the one-cycle latency and each result in order
    initial begin
        rvc_types_pkg::rvc_decode_t expd;
        string                      nm;
        forever begin
            @(negedge i_clk);
            check_value("o_valid timing", {31'b0, exp_valid}, {31'b0, o_valid});
            if (!i_arst_n) begin
                check_value("reset o_decode", 32'd0, o_decode.instr);
                check_value("reset flags", 32'd0,
                            {30'b0, o_decode.is_compressed, o_decode.illegal});
            end else if (o_valid) begin
                if (exp_q.size() == 0) begin
                    proto_errs++;
                    $display("ERROR: o_valid is high but no word is waiting for a result");
                end else begin
                    expd = exp_q.pop_front();
                    nm   = name_q.pop_front();
                    check_value({nm, " instr"}, expd.instr, o_decode.instr);
                    check_value({nm, " is_compressed"}, {31'b0, expd.is_compressed},
                                {31'b0, o_decode.is_compressed});
                    check_value({nm, " illegal"}, {31'b0, expd.illegal},
                                {31'b0, o_decode.illegal});
                end
            end
            exp_valid = i_arst_n & i_valid;
        end
    end

    initial begin
        for (int cyc = 0; cyc < 20000; cyc++) begin
            @(posedge i_clk);
        end
        $display("ERROR: simulation did not finish within 20000 cycles");
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        logic [31:0] r;
        int          wait_cyc;
        i_arst_n = 1'b0;
        i_valid  = 1'b0;
        i_instr  = 32'd0;
        repeat (4) @(posedge i_clk);
        #2;
        i_arst_n = 1'b1;
        idle_cycles(3);

        // Known encodings from the spec tables
        check_value("model c.nop", 32'h0000_0013, ref_decode(32'h0000_0001).instr);
        check_value("model c.ebreak", 32'h0010_0073, ref_decode(32'h0000_9002).instr);
        check_value("model c.li a0,-1", 32'hFFF0_0513, ref_decode(32'h0000_557D).instr);
        check_value("model c.j -2", 32'hFFFF_F06F, ref_decode(32'h0000_BFFD).instr);

        send_half({3'b000, 8'b10110101, 3'b010, 2'b00}, "c.addi4spn");
        send_half({3'b010, 3'b101, 3'b011, 2'b10, 3'b100, 2'b00}, "c.lw");
        send_half({3'b110, 3'b011, 3'b001, 2'b11, 3'b110, 2'b00}, "c.sw");
        send_half(16'h0001, "c.nop");
        send_half({3'b000, 1'b1, 5'd9, 5'b10000, 2'b01}, "c.addi neg");
        send_half({3'b001, 11'b10110100101, 2'b01}, "c.jal neg");
        send_half({3'b001, 11'b01001011010, 2'b01}, "c.jal pos");
        send_half({3'b010, 1'b1, 5'd10, 5'b11111, 2'b01}, "c.li neg");
        send_half({3'b011, 1'b1, 5'd2, 5'b01010, 2'b01}, "c.addi16sp neg");
        send_half({3'b011, 1'b0, 5'd2, 5'b10001, 2'b01}, "c.addi16sp pos");
        send_half({3'b011, 1'b1, 5'd5, 5'b00011, 2'b01}, "c.lui neg");
        send_half({3'b011, 1'b0, 5'd15, 5'b00100, 2'b01}, "c.lui pos");
        send_half({3'b100, 1'b0, 2'b00, 3'b001, 5'd7, 2'b01}, "c.srli");
        send_half({3'b100, 1'b0, 2'b01, 3'b110, 5'd31, 2'b01}, "c.srai");
        send_half({3'b100, 1'b1, 2'b10, 3'b010, 5'b10101, 2'b01}, "c.andi neg");
        for (int k = 0; k < 4; k++) begin
            send_half({3'b100, 1'b0, 2'b11, 3'b011, k[1:0], 3'b101, 2'b01}, "c.sub/xor/or/and");
        end
        send_half({3'b101, 11'b11111111110, 2'b01}, "c.j neg");
        send_half({3'b110, 3'b100, 3'b010, 5'b01101, 2'b01}, "c.beqz neg");
        send_half({3'b111, 3'b011, 3'b111, 5'b10010, 2'b01}, "c.bnez pos");
        send_half({3'b000, 1'b0, 5'd12, 5'd3, 2'b10}, "c.slli");
        send_half({3'b010, 1'b1, 5'd8, 5'b10111, 2'b10}, "c.lwsp");
        send_half({3'b100, 1'b0, 5'd1, 5'd0, 2'b10}, "c.jr");
        send_half({3'b100, 1'b0, 5'd10, 5'd11, 2'b10}, "c.mv");
        send_half(16'h9002, "c.ebreak");
        send_half({3'b100, 1'b1, 5'd6, 5'd0, 2'b10}, "c.jalr");
        send_half({3'b100, 1'b1, 5'd13, 5'd14, 2'b10}, "c.add");
        send_half({3'b110, 6'b101101, 5'd20, 2'b10}, "c.swsp");
        idle_cycles(2);

        send_half(16'h0000, "illegal all-zero");
        send_half({3'b000, 8'd0, 3'b011, 2'b00}, "illegal addi4spn zero");
        for (int k = 0; k < 8; k++) begin
            if (k != 0 && k != 2 && k != 6) begin
                send_half({k[2:0], 11'b01010101010, 2'b00}, "illegal q0 funct3");
            end
            if (k[0]) begin
                send_half({k[2:0], 11'b10101010101, 2'b10}, "illegal q2 funct3");
            end
        end
        send_half({3'b011, 1'b0, 5'd2, 5'd0, 2'b01}, "illegal addi16sp zero");
        send_half({3'b011, 1'b0, 5'd7, 5'd0, 2'b01}, "illegal lui zero");
        send_half({3'b100, 1'b1, 2'b00, 3'b001, 5'd3, 2'b01}, "illegal srli bit12");
        send_half({3'b100, 1'b1, 2'b01, 3'b100, 5'd9, 2'b01}, "illegal srai bit12");
        for (int k = 0; k < 4; k++) begin
            send_half({3'b100, 1'b1, 2'b11, 3'b010, k[1:0], 3'b011, 2'b01}, "illegal alu bit12");
        end
        send_half({3'b000, 1'b1, 5'd4, 5'd2, 2'b10}, "illegal slli bit12");
        send_half({3'b010, 1'b0, 5'd0, 5'd4, 2'b10}, "illegal lwsp rd0");
        send_half(16'h8002, "illegal jr x0");
        idle_cycles(3);

        // Full-width words with idle gaps of 0 to 3 cycles
        for (int i = 0; i < 200; i++) begin
            r = $random(seed);
            send_word({r[31:2], 2'b11}, "pass-through");
            idle_cycles({30'd0, r[5:4]});
        end

        for (int i = 0; i < 2000; i++) begin
            r = $random(seed);
            send_word(r, "random stream");
        end

        idle_cycles(1);
        wait_cyc = 0;
        while (exp_q.size() != 0 && wait_cyc < 50) begin
            @(posedge i_clk);
            wait_cyc++;
        end
        if (exp_q.size() != 0) begin
            tmo_errs++;
            $display("ERROR: timed out with %0d results still outstanding", exp_q.size());
        end
        idle_cycles(4);

        $display("Errors: %0d check, %0d protocol, %0d timeout", chk_errs, proto_errs, tmo_errs);
        if (chk_errs + proto_errs + tmo_errs == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: src/rvc_decoder.sv
`timescale 1ns/1ps

module rvc_decoder (
    input  logic                             i_clk,
    input  logic                             i_arst_n,
    input  logic                             i_valid,
    input  logic [rvc_isa_pkg::INSTR_W-1:0]  i_instr,
    output logic                             o_valid,
    output rvc_types_pkg::rvc_decode_t       o_decode
);

    rvc_types_pkg::rvc_expand_t mem_res;
    rvc_types_pkg::rvc_expand_t alu_res;

    rvc_mem_expander u_mem (
        .i_cinstr (i_instr[rvc_isa_pkg::CINSTR_W-1:0]),
        .o_mem    (mem_res)
    );

    rvc_alu_ctrl_expander u_alu (
        .i_cinstr (i_instr[rvc_isa_pkg::CINSTR_W-1:0]),
        .o_alu    (alu_res)
    );

    rvc_expand_merge u_merge (
        .i_clk    (i_clk),
        .i_arst_n (i_arst_n),
        .i_valid  (i_valid),
        .i_instr  (i_instr),
        .i_mem    (mem_res),
        .i_alu    (alu_res),
        .o_valid  (o_valid),
        .o_decode (o_decode)
    );

endmodule

// File: src/rvc_expand_merge.sv
`timescale 1ns/1ps

module rvc_expand_merge (
    input  logic                             i_clk,
    input  logic                             i_arst_n,
    input  logic                             i_valid,
    input  logic [rvc_isa_pkg::INSTR_W-1:0]  i_instr,
    input  rvc_types_pkg::rvc_expand_t       i_mem,
    input  rvc_types_pkg::rvc_expand_t       i_alu,
    output logic                             o_valid,
    output rvc_types_pkg::rvc_decode_t       o_decode
);

    rvc_types_pkg::rvc_expand_t sel;
    rvc_types_pkg::rvc_decode_t dec_next;

    assign sel = i_mem.hit ? i_mem : i_alu; // At most one owner

    always_comb begin
        dec_next.is_compressed = sel.hit;
        dec_next.illegal       = sel.hit & sel.illegal;
        dec_next.instr         = (sel.hit && !sel.illegal) ? sel.instr : i_instr;
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_valid  <= 1'b0;
            o_decode <= '0;
        end else begin
            o_valid <= i_valid;
            if (i_valid) begin
                o_decode <= dec_next;
            end
        end
    end

    a_single_owner: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_valid |-> !(i_mem.hit && i_alu.hit));

    // Some expander owns every compressed word
    a_owner_quad: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_valid |-> ((i_mem.hit || i_alu.hit) ==
                     (i_instr[1:0] != rvc_isa_pkg::QUAD_NONE)));

    a_valid_known: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        !$isunknown(o_valid));

endmodule

// File: src/rvc_alu_ctrl_expander.sv
`timescale 1ns/1ps

module rvc_alu_ctrl_expander (
    input  logic [rvc_isa_pkg::CINSTR_W-1:0] i_cinstr,
    output rvc_types_pkg::rvc_expand_t       o_alu
);

    logic [1:0]  quad;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [4:0]  rs2;
    logic [4:0]  rd_p;    // rd'/rs1'
    logic [4:0]  rs2_p;
    logic [11:0] imm6_sext;
    logic [11:0] sp16_imm;
    logic [11:0] j_off;
    logic [12:0] b_off;
    logic [2:0]  alu_f3;
    logic        hit;

    assign quad   = i_cinstr[1:0];
    assign funct3 = i_cinstr[15:13];
    assign rd     = i_cinstr[11:7];
    assign rs2    = i_cinstr[6:2];
    assign rd_p   = {rvc_isa_pkg::RVC_PREFIX, i_cinstr[9:7]};
    assign rs2_p  = {rvc_isa_pkg::RVC_PREFIX, i_cinstr[4:2]};

    assign imm6_sext = {{7{i_cinstr[12]}}, i_cinstr[6:2]};
    assign sp16_imm  = {{3{i_cinstr[12]}}, i_cinstr[4:3], i_cinstr[5], i_cinstr[2],
                        i_cinstr[6], 4'b0};
    assign j_off     = {i_cinstr[12], i_cinstr[8], i_cinstr[10:9], i_cinstr[6], i_cinstr[7],
                        i_cinstr[2], i_cinstr[11], i_cinstr[5:3], 1'b0};
    assign b_off     = {{4{i_cinstr[12]}}, i_cinstr[12], i_cinstr[6:5], i_cinstr[2],
                        i_cinstr[11:10], i_cinstr[4:3], 1'b0};

    assign hit = (quad == rvc_isa_pkg::QUAD_1) ||
                 ((quad == rvc_isa_pkg::QUAD_2) &&
                  ((funct3 == rvc_isa_pkg::C2_SLLI) || (funct3 == rvc_isa_pkg::C2_JR_MV_ADD)));

    always_comb begin
        case (i_cinstr[6:5])
            2'b00:   alu_f3 = rvc_isa_pkg::F3_ADD_SUB; // SUB
            2'b01:   alu_f3 = rvc_isa_pkg::F3_XOR;
            2'b10:   alu_f3 = rvc_isa_pkg::F3_OR;
            default: alu_f3 = rvc_isa_pkg::F3_AND;
        endcase
    end

    always_comb begin
        o_alu.hit     = hit;
        o_alu.illegal = 1'b0;
        o_alu.instr   = '0;
        if (quad == rvc_isa_pkg::QUAD_1) begin
            case (funct3)
                rvc_isa_pkg::C1_ADDI: begin
                    o_alu.instr = {imm6_sext, rd, rvc_isa_pkg::F3_ADD_SUB, rd,
                                   rvc_isa_pkg::OPC_OP_IMM};
                end
                rvc_isa_pkg::C1_JAL, rvc_isa_pkg::C1_J: begin
                    // Link to ra only for C.JAL
                    o_alu.instr = {j_off[11], j_off[10:1], j_off[11], {8{j_off[11]}},
                                   funct3[2] ? rvc_isa_pkg::REG_ZERO : rvc_isa_pkg::REG_RA,
                                   rvc_isa_pkg::OPC_JAL};
                end
                rvc_isa_pkg::C1_LI: begin
                    o_alu.instr = {imm6_sext, rvc_isa_pkg::REG_ZERO, rvc_isa_pkg::F3_ADD_SUB, rd,
                                   rvc_isa_pkg::OPC_OP_IMM};
                end
                rvc_isa_pkg::C1_LUI_ADDI16SP: begin
                    if (rd == rvc_isa_pkg::REG_SP) begin
                        o_alu.instr = {sp16_imm, rvc_isa_pkg::REG_SP, rvc_isa_pkg::F3_ADD_SUB,
                                       rvc_isa_pkg::REG_SP, rvc_isa_pkg::OPC_OP_IMM};
                    end else begin
                        o_alu.instr = {{15{i_cinstr[12]}}, i_cinstr[6:2], rd,
                                       rvc_isa_pkg::OPC_LUI};
                    end
                    o_alu.illegal = ({i_cinstr[12], i_cinstr[6:2]} == 6'd0);
                end
                rvc_isa_pkg::C1_MISC_ALU: begin
                    case (i_cinstr[11:10])
                        2'b00, 2'b01: begin // SRLI, SRAI by bit 10
                            o_alu.instr   = {1'b0, i_cinstr[10], 5'b0, i_cinstr[6:2], rd_p,
                                             rvc_isa_pkg::F3_SR, rd_p, rvc_isa_pkg::OPC_OP_IMM};
                            o_alu.illegal = i_cinstr[12];
                        end
                        2'b10: begin
                            o_alu.instr = {imm6_sext, rd_p, rvc_isa_pkg::F3_AND, rd_p,
                                           rvc_isa_pkg::OPC_OP_IMM};
                        end
                        default: begin
                            o_alu.instr   = {1'b0, (i_cinstr[6:5] == 2'b00), 5'b0, rs2_p, rd_p,
                                             alu_f3, rd_p, rvc_isa_pkg::OPC_OP};
                            o_alu.illegal = i_cinstr[12]; // SUBW, ADDW and reserved
                        end
                    endcase
                end
                default: begin // BEQZ, BNEZ
                    o_alu.instr = {b_off[12], b_off[10:5], rvc_isa_pkg::REG_ZERO, rd_p,
                                   funct3[0] ? rvc_isa_pkg::F3_BNE : rvc_isa_pkg::F3_BEQ,
                                   b_off[4:1], b_off[11], rvc_isa_pkg::OPC_BRANCH};
                end
            endcase
        end else if (hit) begin
            if (funct3 == rvc_isa_pkg::C2_SLLI) begin
                o_alu.instr   = {7'b0, i_cinstr[6:2], rd, rvc_isa_pkg::F3_SLL, rd,
                                 rvc_isa_pkg::OPC_OP_IMM};
                o_alu.illegal = i_cinstr[12];
            end else if (!i_cinstr[12]) begin
                if (rs2 == rvc_isa_pkg::REG_ZERO) begin // JR
                    o_alu.instr   = {12'b0, rd, 3'b000, rvc_isa_pkg::REG_ZERO,
                                     rvc_isa_pkg::OPC_JALR};
                    o_alu.illegal = (rd == rvc_isa_pkg::REG_ZERO);
                end else begin // MV
                    o_alu.instr = {7'b0, rs2, rvc_isa_pkg::REG_ZERO, rvc_isa_pkg::F3_ADD_SUB, rd,
                                   rvc_isa_pkg::OPC_OP};
                end
            end else if (rs2 != rvc_isa_pkg::REG_ZERO) begin // ADD
                o_alu.instr = {7'b0, rs2, rd, rvc_isa_pkg::F3_ADD_SUB, rd, rvc_isa_pkg::OPC_OP};
            end else if (rd == rvc_isa_pkg::REG_ZERO) begin // EBREAK
                o_alu.instr = {12'd1, rvc_isa_pkg::REG_ZERO, 3'b000, rvc_isa_pkg::REG_ZERO,
                               rvc_isa_pkg::OPC_SYSTEM};
            end else begin // JALR
                o_alu.instr = {12'b0, rd, 3'b000, rvc_isa_pkg::REG_RA, rvc_isa_pkg::OPC_JALR};
            end
        end
    end

    always_comb begin
        assert (!o_alu.illegal || o_alu.hit)
            else $error("ALU expander flags illegal on a halfword it does not own");
    end

endmodule

// File: src/rvc_mem_expander.sv
`timescale 1ns/1ps

module rvc_mem_expander (
    input  logic [rvc_isa_pkg::CINSTR_W-1:0] i_cinstr,
    output rvc_types_pkg::rvc_expand_t       o_mem
);

    logic [1:0] quad;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [4:0] rs2;
    logic [4:0] rs1_p;
    logic [4:0] rd_rs2_p;
    logic [9:0] addi4spn_imm;
    logic [6:0] lw_off;
    logic [7:0] lwsp_off;
    logic [7:0] swsp_off;
    logic       hit;

    assign quad     = i_cinstr[1:0];
    assign funct3   = i_cinstr[15:13];
    assign rd       = i_cinstr[11:7];
    assign rs2      = i_cinstr[6:2];
    assign rs1_p    = {rvc_isa_pkg::RVC_PREFIX, i_cinstr[9:7]};
    assign rd_rs2_p = {rvc_isa_pkg::RVC_PREFIX, i_cinstr[4:2]};

    // Scrambled immediates, already scaled by 4
    assign addi4spn_imm = {i_cinstr[10:7], i_cinstr[12:11], i_cinstr[5], i_cinstr[6], 2'b00};
    assign lw_off       = {i_cinstr[5], i_cinstr[12:10], i_cinstr[6], 2'b00};
    assign lwsp_off     = {i_cinstr[3:2], i_cinstr[12], i_cinstr[6:4], 2'b00};
    assign swsp_off     = {i_cinstr[8:7], i_cinstr[12:9], 2'b00};

    // Quadrant 2 funct3 000 and 100 belong to the ALU expander
    assign hit = (quad == rvc_isa_pkg::QUAD_0) ||
                 ((quad == rvc_isa_pkg::QUAD_2) &&
                  (funct3 != rvc_isa_pkg::C2_SLLI) &&
                  (funct3 != rvc_isa_pkg::C2_JR_MV_ADD));

    always_comb begin
        o_mem.hit     = hit;
        o_mem.illegal = 1'b0;
        o_mem.instr   = '0;
        if (quad == rvc_isa_pkg::QUAD_0) begin
            case (funct3)
                rvc_isa_pkg::C0_ADDI4SPN: begin
                    o_mem.instr   = {2'b00, addi4spn_imm, rvc_isa_pkg::REG_SP,
                                     rvc_isa_pkg::F3_ADD_SUB, rd_rs2_p, rvc_isa_pkg::OPC_OP_IMM};
                    o_mem.illegal = (i_cinstr[12:5] == 8'd0); // Also catches all-zero word
                end
                rvc_isa_pkg::C0_LW: begin
                    o_mem.instr = {5'b0, lw_off, rs1_p, rvc_isa_pkg::F3_LW_SW, rd_rs2_p,
                                   rvc_isa_pkg::OPC_LOAD};
                end
                rvc_isa_pkg::C0_SW: begin
                    o_mem.instr = {5'b0, lw_off[6:5], rd_rs2_p, rs1_p, rvc_isa_pkg::F3_LW_SW,
                                   lw_off[4:0], rvc_isa_pkg::OPC_STORE};
                end
                default: o_mem.illegal = 1'b1; // FP, RV64 and reserved slots
            endcase
        end else if (quad == rvc_isa_pkg::QUAD_2) begin
            case (funct3)
                rvc_isa_pkg::C2_LWSP: begin
                    o_mem.instr   = {4'b0, lwsp_off, rvc_isa_pkg::REG_SP, rvc_isa_pkg::F3_LW_SW,
                                     rd, rvc_isa_pkg::OPC_LOAD};
                    o_mem.illegal = (rd == rvc_isa_pkg::REG_ZERO);
                end
                rvc_isa_pkg::C2_SWSP: begin
                    o_mem.instr = {4'b0, swsp_off[7:5], rs2, rvc_isa_pkg::REG_SP,
                                   rvc_isa_pkg::F3_LW_SW, swsp_off[4:0], rvc_isa_pkg::OPC_STORE};
                end
                default: o_mem.illegal = hit; // FLDSP, LDSP, FSDSP, SDSP
            endcase
        end
    end

    always_comb begin
        assert (!o_mem.illegal || o_mem.hit)
            else $error("mem expander flags illegal on a halfword it does not own");
    end

endmodule

// File: src/rvc_types_pkg.sv
package rvc_types_pkg;

    // Result of one expander
    typedef struct packed {
        logic                             hit;     // Halfword belongs to this group
        logic                             illegal; // Reserved encoding
        logic [rvc_isa_pkg::INSTR_W-1:0]  instr;
    } rvc_expand_t;

    // Registered decode result
    typedef struct packed {
        logic [rvc_isa_pkg::INSTR_W-1:0]  instr;
        logic                             is_compressed;
        logic                             illegal;
    } rvc_decode_t;

endpackage

// File: src/rvc_isa_pkg.sv
package rvc_isa_pkg;

    // Quadrant field, instr[1:0]
    localparam logic [1:0] QUAD_0    = 2'b00;
    localparam logic [1:0] QUAD_1    = 2'b01;
    localparam logic [1:0] QUAD_2    = 2'b10;
    localparam logic [1:0] QUAD_NONE = 2'b11; // Uncompressed word

    // Quadrant 0 funct3
    localparam logic [2:0] C0_ADDI4SPN = 3'b000;
    localparam logic [2:0] C0_LW       = 3'b010;
    localparam logic [2:0] C0_SW       = 3'b110;

    // Quadrant 1 funct3
    localparam logic [2:0] C1_ADDI         = 3'b000;
    localparam logic [2:0] C1_JAL          = 3'b001; // RV32 only
    localparam logic [2:0] C1_LI           = 3'b010;
    localparam logic [2:0] C1_LUI_ADDI16SP = 3'b011;
    localparam logic [2:0] C1_MISC_ALU     = 3'b100;
    localparam logic [2:0] C1_J            = 3'b101;
    localparam logic [2:0] C1_BEQZ         = 3'b110;
    localparam logic [2:0] C1_BNEZ         = 3'b111;

    // Quadrant 2 funct3
    localparam logic [2:0] C2_SLLI      = 3'b000;
    localparam logic [2:0] C2_LWSP      = 3'b010;
    localparam logic [2:0] C2_JR_MV_ADD = 3'b100;
    localparam logic [2:0] C2_SWSP      = 3'b110;

    // Base opcodes
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    // Base funct3
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SR      = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_LW_SW   = 3'b010;
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;

    // Fixed registers
    localparam logic [4:0] REG_ZERO = 5'd0;
    localparam logic [4:0] REG_RA   = 5'd1;
    localparam logic [4:0] REG_SP   = 5'd2;

    // Upper bits of a 3-bit register field, x8..x15
    localparam logic [1:0] RVC_PREFIX = 2'b01;

    localparam int INSTR_W  = 32;
    localparam int CINSTR_W = 16;

endpackage
